//--- Bender.yml
package:
  name: leaf_node

sources:
  - include_dirs:
      - design
    files:
      - design/leaf_pkg.sv
      - design/stream_if.sv
      - design/port_fifo.sv
      - design/leaf_ingress.sv
      - design/pair_adder_kernel.sv
      - design/leaf_egress.sv
      - design/leaf_node.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_leaf_node.sv

//--- design/leaf_defines.svh
`ifndef LEAF_DEFINES_SVH
`define LEAF_DEFINES_SVH

// tree packet fields from the msb down are vld, leaf, port, addr and payload.
`define LEAF_PACKET_BITS 49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_LEAF_BITS 5
`define LEAF_PORT_BITS 4
`define LEAF_ADDR_BITS 7

// kernel port counts.
`define LEAF_NUM_IN_PORTS 6
`define LEAF_NUM_OUT_PORTS 3

// entries per input fifo.
`define LEAF_FIFO_DEPTH 4

`endif

//--- design/leaf_egress.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module leaf_egress (
    input wire clk,
    input wire rst_n,
    input wire resend,
    input wire route_we,
    input wire [1:0] route_idx,
    input wire leaf_pkg::route_t route_data,
    stream_if.sink res [`LEAF_NUM_OUT_PORTS],
    output leaf_pkg::leaf_packet_t dout
);
    import leaf_pkg::*;

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int IDX_BITS = $clog2(NUM_OUT);

    route_t route_tab [NUM_OUT];
    leaf_word_t res_data [NUM_OUT];
    leaf_tag_t res_tag [NUM_OUT];
    logic [NUM_OUT-1:0] req;
    logic [NUM_OUT-1:0] gnt;
    logic [IDX_BITS-1:0] sel;
    logic [IDX_BITS-1:0] last_q;
    leaf_packet_t pkt_d;
    leaf_packet_t pkt_q;

    for (genvar i = 0; i < NUM_OUT; i++) begin : g_res
        assign req[i] = res[i].vld;
        assign res_data[i] = res[i].data;
        assign res_tag[i] = res[i].tag;
        assign res[i].ack = gnt[i];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_OUT; i++) begin
                route_tab[i] <= '0;
            end
        end else if (route_we) begin
            route_tab[route_idx] <= route_data;
        end
    end

    // round robin search starting just after the last grant.
    always_comb begin
        int idx;
        logic found;
        gnt = '0;
        sel = last_q;
        found = 1'b0;
        for (int k = 1; k <= NUM_OUT; k++) begin
            idx = (int'(last_q) + k) % NUM_OUT;
            if (!resend && !found && req[idx]) begin
                gnt[idx] = 1'b1;
                sel = IDX_BITS'(idx);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        pkt_d.vld = 1'b1;
        pkt_d.leaf = route_tab[sel].leaf;
        pkt_d.port = route_tab[sel].port;
        pkt_d.addr = res_tag[sel];
        pkt_d.payload = res_data[sel];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= IDX_BITS'(NUM_OUT - 1);
            pkt_q <= '0;
        end else if (resend) begin
            // a packet caught by resend is held and sent once resend drops.
            pkt_q <= pkt_q;
        end else if (|gnt) begin
            last_q <= sel;
            pkt_q <= pkt_d;
        end else begin
            pkt_q <= '0;
        end
    end

    assign dout = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

//--- design/leaf_ingress.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module leaf_ingress #(
    parameter logic [`LEAF_LEAF_BITS-1:0] LEAF_ID = '0
) (
    input wire clk,
    input wire rst_n,
    input wire leaf_pkg::leaf_packet_t din,
    stream_if.source push [`LEAF_NUM_IN_PORTS],
    output logic route_we,
    output logic [1:0] route_idx,
    output leaf_pkg::route_t route_data
);
    import leaf_pkg::*;

    localparam int NUM_IN = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int PORT_BITS = `LEAF_PORT_BITS;
    localparam int ADDR_BITS = `LEAF_ADDR_BITS;

    logic armed;
    logic hit;

    // link is ignored until the first clock edge after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    assign hit = armed && din.vld && (din.leaf == LEAF_ID);

    // push vld lasts only the arrival cycle and a full fifo simply drops it.
    for (genvar i = 0; i < NUM_IN; i++) begin : g_push
        assign push[i].vld = hit && (din.port == PORT_BITS'(i + 1));
        assign push[i].data = din.payload;
        assign push[i].tag = din.addr;
    end

    // port 0 is the configuration port and addr selects the output route.
    assign route_we = hit && (din.port == '0) && (din.addr != '0)
                      && (din.addr <= ADDR_BITS'(NUM_OUT));
    assign route_idx = din.addr[1:0] - 2'd1;
    assign route_data = route_t'(din.payload[$bits(route_t)-1:0]);

endmodule

`default_nettype wire

//--- design/leaf_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module leaf_node #(
    parameter logic [`LEAF_LEAF_BITS-1:0] LEAF_ID = 5'd3
) (
    input wire clk,
    input wire rst_n,
    input wire [`LEAF_PACKET_BITS-1:0] din_leaf_bft2interface,
    output wire [`LEAF_PACKET_BITS-1:0] dout_leaf_interface2bft,
    input wire resend
);
    import leaf_pkg::*;

    localparam int NUM_IN = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;

    logic route_we;
    logic [1:0] route_idx;
    route_t route_data;

    // ingress to fifo, fifo to kernel, kernel to egress.
    stream_if push_s [NUM_IN] ();
    stream_if pop_s [NUM_IN] ();
    stream_if res_s [NUM_OUT] ();

    leaf_ingress #(
        .LEAF_ID(LEAF_ID)
    ) u_ingress (
        .clk(clk),
        .rst_n(rst_n),
        .din(din_leaf_bft2interface),
        .push(push_s),
        .route_we(route_we),
        .route_idx(route_idx),
        .route_data(route_data)
    );

    for (genvar i = 0; i < NUM_IN; i++) begin : g_fifo
        port_fifo u_fifo (
            .clk(clk),
            .rst_n(rst_n),
            .wr(push_s[i]),
            .rd(pop_s[i])
        );
    end

    pair_adder_kernel u_kernel (
        .clk(clk),
        .rst_n(rst_n),
        .in_s(pop_s),
        .out_s(res_s)
    );

    leaf_egress u_egress (
        .clk(clk),
        .rst_n(rst_n),
        .resend(resend),
        .route_we(route_we),
        .route_idx(route_idx),
        .route_data(route_data),
        .res(res_s),
        .dout(dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

//--- design/leaf_pkg.sv
`default_nettype none

`include "leaf_defines.svh"

package leaf_pkg;

    typedef logic [`LEAF_PAYLOAD_BITS-1:0] leaf_word_t;

    typedef logic [`LEAF_ADDR_BITS-1:0] leaf_tag_t;

    // one tree packet as it appears on the link.
    typedef struct packed {
        logic vld;
        logic [`LEAF_LEAF_BITS-1:0] leaf;
        logic [`LEAF_PORT_BITS-1:0] port;
        leaf_tag_t addr;
        leaf_word_t payload;
    } leaf_packet_t;

    // destination of one kernel output.
    typedef struct packed {
        logic [`LEAF_LEAF_BITS-1:0] leaf;
        logic [`LEAF_PORT_BITS-1:0] port;
    } route_t;

endpackage

`default_nettype wire

//--- design/pair_adder_kernel.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module pair_adder_kernel (
    input wire clk,
    input wire rst_n,
    stream_if.sink in_s [`LEAF_NUM_IN_PORTS],
    stream_if.source out_s [`LEAF_NUM_OUT_PORTS]
);
    import leaf_pkg::*;

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;

    // output j sums inputs 2j and 2j+1, counted from zero.
    for (genvar j = 0; j < NUM_OUT; j++) begin : g_pair
        leaf_word_t sum_q;
        leaf_tag_t tag_q;
        logic vld_q;
        logic take;

        // both words are popped together once the result slot is free.
        assign take = in_s[2*j].vld && in_s[2*j+1].vld && (!vld_q || out_s[j].ack);

        assign in_s[2*j].ack = take;
        assign in_s[2*j+1].ack = take;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vld_q <= 1'b0;
            end else if (take) begin
                vld_q <= 1'b1;
            end else if (out_s[j].ack) begin
                vld_q <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                sum_q <= in_s[2*j].data + in_s[2*j+1].data;
                tag_q <= in_s[2*j].tag;
            end
        end

        assign out_s[j].vld = vld_q;
        assign out_s[j].data = sum_q;
        assign out_s[j].tag = tag_q;
    end

endmodule

`default_nettype wire

//--- design/port_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module port_fifo (
    input wire clk,
    input wire rst_n,
    stream_if.sink wr,
    stream_if.source rd
);
    import leaf_pkg::*;

    localparam int DEPTH = `LEAF_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

    leaf_word_t data_mem [DEPTH];
    leaf_tag_t tag_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;
    logic do_push;
    logic do_pop;

    assign wr.ack = (count != FULL_COUNT);
    assign rd.vld = (count != '0);
    assign rd.data = data_mem[rd_ptr];
    assign rd.tag = tag_mem[rd_ptr];

    assign do_push = wr.vld && wr.ack;
    assign do_pop = rd.vld && rd.ack;

    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= wr.data;
            tag_mem[wr_ptr] <= wr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count unchanged.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ack word stream; a word moves when vld and ack are both high.
interface stream_if;
    import leaf_pkg::*;

    logic vld;
    logic ack;
    leaf_word_t data;
    leaf_tag_t tag;

    modport source (
        output vld,
        output data,
        output tag,
        input ack
    );

    modport sink (
        input vld,
        input data,
        input tag,
        output ack
    );

endinterface

`default_nettype wire

//--- filelist.f
+incdir+design
design/leaf_pkg.sv
design/stream_if.sv
design/port_fifo.sv
design/leaf_ingress.sv
design/pair_adder_kernel.sv
design/leaf_egress.sv
design/leaf_node.sv
sim/tb_leaf_node.sv

//--- sim/tb_leaf_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_defines.svh"

module tb_leaf_node;
    import leaf_pkg::*;

    localparam int NUM_IN = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int DEPTH = `LEAF_FIFO_DEPTH;
    // the sequence needs a few hundred cycles, so this leaves a wide margin.
    localparam int CYCLE_LIMIT = 3000;

    logic clk = 1'b0;
    logic rst_n;
    logic resend;
    leaf_packet_t din;
    leaf_packet_t dout;

    logic [31:0] lcg_state = 32'd55;
    int cycles = 0;
    int produced = 0;
    int checked = 0;
    bit hold = 1'b0;
    bit [NUM_OUT-1:0] slot_used = '0;
    route_t model_route [NUM_OUT] = '{default: '0};
    // each entry is {tag, word}.
    logic [38:0] in_q [NUM_IN][$];
    leaf_packet_t exp_q [NUM_OUT][$];
    leaf_packet_t exp_head [NUM_OUT] = '{default: '0};
    logic [NUM_OUT-1:0] exp_vld = '0;
    wire [NUM_OUT-1:0] route_hit;

    leaf_node #(
        .LEAF_ID(5'd3)
    ) u_leaf_node (
        .clk(clk),
        .rst_n(rst_n),
        .din_leaf_bft2interface(din),
        .dout_leaf_interface2bft(dout),
        .resend(resend)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("timeout: the results did not drain within the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void refresh_heads();
        for (int j = 0; j < NUM_OUT; j++) begin
            exp_vld[j] = (exp_q[j].size() != 0);
            exp_head[j] = exp_vld[j] ? exp_q[j][0] : '0;
        end
    endfunction

    // while resend holds egress, each kernel output keeps one finished pair.
    function automatic void try_pair(int j);
        logic [38:0] a;
        logic [38:0] b;
        while (in_q[2*j].size() != 0 && in_q[2*j+1].size() != 0 && !(hold && slot_used[j])) begin
            a = in_q[2*j].pop_front();
            b = in_q[2*j+1].pop_front();
            exp_q[j].push_back(leaf_packet_t'{1'b1, model_route[j].leaf, model_route[j].port,
                                              a[38:32], a[31:0] + b[31:0]});
            produced++;
            slot_used[j] = hold;
        end
        refresh_heads();
    endfunction

    function automatic void model_packet(leaf_packet_t pkt);
        int p;
        p = int'(pkt.port);
        if (pkt.vld && pkt.leaf == 5'd3) begin
            if (p >= 1 && p <= NUM_IN) begin
                if (in_q[p-1].size() < DEPTH) begin
                    in_q[p-1].push_back({pkt.addr, pkt.payload});
                end
                try_pair((p - 1) / 2);
            end else if (p == 0 && pkt.addr >= 1 && pkt.addr <= NUM_OUT) begin
                model_route[pkt.addr - 1] = pkt.payload[8:0];
            end
        end
    endfunction

    task automatic send(input leaf_packet_t pkt);
        @(negedge clk);
        din = pkt;
        model_packet(pkt);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            din = '0;
        end
    endtask

    task automatic send_word(input int port);
        logic [31:0] r;
        r = lcg_next();
        send(leaf_packet_t'{1'b1, 5'd3, 4'(port), r[30:24], lcg_next()});
    endtask

    task automatic set_routes(input int base);
        logic [31:0] r;
        for (int j = 0; j < NUM_OUT; j++) begin
            r = lcg_next();
            send(leaf_packet_t'{1'b1, 5'd3, 4'd0, 7'(j + 1), {23'd0, 5'(base + j), r[3:0]}});
        end
        // wrong leaf, clear vld and out-of-range addr must not touch the table.
        send(leaf_packet_t'{1'b1, 5'd9, 4'd0, 7'd1, 32'h1ff});
        send(leaf_packet_t'{1'b0, 5'd3, 4'd0, 7'd2, 32'h1ff});
        send(leaf_packet_t'{1'b1, 5'd3, 4'd0, 7'd0, 32'h1ff});
        send(leaf_packet_t'{1'b1, 5'd3, 4'd0, 7'd5, 32'h1ff});
        idle(2);
    endtask

    // pairs in random order, sometimes split by a packet that must be ignored.
    task automatic run_pairs(input int n);
        logic [31:0] r;
        leaf_packet_t junk;
        int j;
        for (int k = 0; k < n; k++) begin
            r = lcg_next();
            j = int'(r[31:16] % NUM_OUT);
            send_word(2*j + 1 + int'(r[8]));
            junk = leaf_packet_t'{1'b1, 5'd3, 4'd1 + 4'(r[7:0] % 6), r[14:8], lcg_next()};
            case (r[23:16] % 3)
                0: junk.vld = 1'b0;
                1: junk.leaf = 5'd4 + 5'(r[20:16] % 31);
                default: junk.port = 4'd7 + 4'(r[23:16] % 9);
            endcase
            if (r[9]) begin
                send(junk);
            end
            send_word(2*j + 2 - int'(r[8]));
        end
    endtask

    task automatic set_resend(input logic v);
        @(negedge clk);
        din = '0;
        resend = v;
        hold = v;
        slot_used = '0;
        for (int j = 0; j < NUM_OUT; j++) begin
            try_pair(j);
        end
    endtask

    // output 0 is already registered in egress and output 1 sits in the kernel
    // when resend rises, so both must come out once it drops.
    task automatic resend_after_grant();
        send_word(1);
        send_word(2);
        send_word(3);
        send_word(4);
        set_resend(1'b1);
        idle(3);
        set_resend(1'b0);
    endtask

    task automatic wait_drained();
        do begin
            @(negedge clk);
            din = '0;
        end while (exp_vld != '0);
    endtask

    // retire the head of whichever output the packet was routed from.
    always @(posedge clk) begin
        if (rst_n && dout.vld) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                if (route_hit[j] && exp_q[j].size() != 0) begin
                    void'(exp_q[j].pop_front());
                    checked++;
                end
            end
            refresh_heads();
        end
    end

    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n) dout.vld || dout == '0)
        else abort_run($sformatf("[FAIL] %0d ns: idle dout is %h", $time, $sampled(dout)));

    a_resend_zero: assert property (@(posedge clk) disable iff (!rst_n) resend |-> dout == '0)
        else abort_run($sformatf("[FAIL] %0d ns: dout %h during resend", $time, $sampled(dout)));

    a_known_route: assert property (@(posedge clk) disable iff (!rst_n)
        dout.vld |-> route_hit != '0)
        else abort_run($sformatf("[FAIL] %0d ns: dout %h has no known route", $time,
                                 $sampled(dout)));

    for (genvar j = 0; j < NUM_OUT; j++) begin : g_check
        assign route_hit[j] = dout.vld && dout.leaf == model_route[j].leaf
                              && dout.port == model_route[j].port;

        a_match: assert property (@(posedge clk) disable iff (!rst_n)
            route_hit[j] |-> (exp_vld[j] && dout == exp_head[j]))
            else abort_run($sformatf("[FAIL] %0d ns: output %0d sent %h, expected %h", $time, j,
                                     $sampled(dout), $sampled(exp_head[j])));
    end

    initial begin
        int leftover;
        rst_n = 1'b0;
        resend = 1'b0;
        din = '0;
        refresh_heads();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        idle(20);
        set_routes(10);
        run_pairs(40);
        wait_drained();
        set_routes(20);
        run_pairs(15);
        wait_drained();
        resend_after_grant();
        wait_drained();
        idle(3);
        // six pairs per output against one kernel slot and four fifo entries.
        set_resend(1'b1);
        for (int j = 0; j < NUM_OUT; j++) begin
            for (int k = 0; k < 6; k++) begin
                send_word(2*j + 1);
                send_word(2*j + 2);
            end
        end
        idle(5);
        set_resend(1'b0);
        wait_drained();
        idle(20);
        leftover = 0;
        for (int i = 0; i < NUM_IN; i++) begin
            leftover += in_q[i].size();
        end
        if (checked != produced || leftover != 0) begin
            abort_run($sformatf("only %0d of %0d results arrived, %0d words left unpaired",
                                checked, produced, leftover));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
